//--- include/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath and address width
`define CORE_XLEN      32
`define CORE_REG_COUNT 32
`define CORE_RESET_PC  32'h0000_0000

// instruction field positions
`define CORE_OP_HI     31
`define CORE_OP_LO     26
`define CORE_RD_HI     4
`define CORE_RD_LO     0
`define CORE_RJ_HI     9
`define CORE_RJ_LO     5
`define CORE_RK_HI     14
`define CORE_RK_LO     10
`define CORE_SI12_HI   21
`define CORE_SI12_LO   10
`define CORE_SI20_HI   24
`define CORE_SI20_LO   5
// branch offset in words
`define CORE_OFFS16_HI 25
`define CORE_OFFS16_LO 10

`endif

//--- logic/core_pkg.sv
`default_nettype none

`include "core_macros.svh"

package core_pkg;

    typedef logic [$clog2(`CORE_REG_COUNT)-1:0] reg_idx_t;

    // OP_NOP stands in for every undefined opcode
    typedef enum logic [5:0] {
        OP_NOP   = 6'd0,
        OP_ADD   = 6'd1,
        OP_SUB   = 6'd2,
        OP_AND   = 6'd3,
        OP_OR    = 6'd4,
        OP_XOR   = 6'd5,
        OP_SLT   = 6'd6,
        OP_ADDI  = 6'd8,
        OP_LU12I = 6'd9,
        OP_BEQ   = 6'd16,
        OP_BNE   = 6'd17,
        OP_B     = 6'd18
    } core_op_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [`CORE_XLEN-1:0] instr;
    } fetch_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        core_op_t              op;
        reg_idx_t              rd;
        reg_idx_t              rj;
        // second source, rd for branches
        reg_idx_t              rk;
        logic [`CORE_XLEN-1:0] val_j;
        logic [`CORE_XLEN-1:0] val_k;
        logic [`CORE_XLEN-1:0] imm;
        logic                  wen;
    } issue_t;

endpackage

`default_nettype wire

//--- logic/fetch_unit.sv
`default_nettype none

`include "core_macros.svh"

module fetch_unit import core_pkg::*; (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  i_redirect,
    input  logic [`CORE_XLEN-1:0] i_redirect_pc,
    output logic                  o_wb_cyc,
    output logic                  o_wb_stb,
    output logic                  o_wb_we,
    output logic [`CORE_XLEN-1:0] o_wb_adr,
    input  logic [`CORE_XLEN-1:0] i_wb_dat,
    input  logic                  i_wb_ack,
    output logic                  o_valid,
    output fetch_t                o_fetch
);

    logic [`CORE_XLEN-1:0] pc_q;
    logic [`CORE_XLEN-1:0] adr_q;
    logic [`CORE_XLEN-1:0] start_pc;
    logic                  cyc_q;
    logic                  stb_q;
    logic                  stale_q;
    logic                  done;

    assign done     = cyc_q & i_wb_ack;
    assign start_pc = i_redirect ? i_redirect_pc : pc_q;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pc_q <= `CORE_RESET_PC;
        end else if (i_redirect) begin
            pc_q <= i_redirect_pc;
        end else if (done && !stale_q) begin
            pc_q <= pc_q + `CORE_XLEN'(4);
        end
    end

    // classic cycle, idle for one clock after each ack
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            cyc_q   <= 1'b0;
            stb_q   <= 1'b0;
            stale_q <= 1'b0;
        end else if (done) begin
            cyc_q   <= 1'b0;
            stb_q   <= 1'b0;
            stale_q <= 1'b0;
        end else if (!cyc_q) begin
            cyc_q <= 1'b1;
            stb_q <= 1'b1;
        end else if (i_redirect) begin
            // word in flight belongs to the wrong path
            stale_q <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!cyc_q) begin
            adr_q <= start_pc;
        end
    end

    assign o_wb_cyc = cyc_q;
    assign o_wb_stb = stb_q;
    assign o_wb_we  = 1'b0;
    assign o_wb_adr = adr_q;

    assign o_valid       = done & ~stale_q;
    assign o_fetch.pc    = adr_q;
    assign o_fetch.instr = i_wb_dat;

    stb_within_cyc: assert property (@(posedge aclk) disable iff (!aresetn)
        o_wb_stb |-> o_wb_cyc);

    adr_held_until_ack: assert property (@(posedge aclk) disable iff (!aresetn)
        o_wb_stb && !i_wb_ack |=> o_wb_stb && $stable(o_wb_adr));

endmodule

`default_nettype wire

//--- logic/stage_reg.sv
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     aclk,
    input  logic     aresetn,
    input  logic     i_flush,
    input  logic     i_valid,
    input  payload_t i_data,
    output logic     o_valid,
    output payload_t o_data
);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid & ~i_flush;
        end
    end

    // payload follows the input every cycle
    always_ff @(posedge aclk) begin
        o_data <= i_data;
    end

endmodule

`default_nettype wire

//--- logic/register_file.sv
`default_nettype none

`include "core_macros.svh"

module register_file import core_pkg::*; (
    input  logic                  aclk,
    input  reg_idx_t              i_raddr_j,
    input  reg_idx_t              i_raddr_k,
    output logic [`CORE_XLEN-1:0] o_rdata_j,
    output logic [`CORE_XLEN-1:0] o_rdata_k,
    input  logic                  i_wen,
    input  reg_idx_t              i_waddr,
    input  logic [`CORE_XLEN-1:0] i_wdata
);

    logic [`CORE_XLEN-1:0] regs [`CORE_REG_COUNT];

    always_ff @(posedge aclk) begin
        if (i_wen) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // r0 reads zero, same-cycle write goes straight through
    function automatic logic [`CORE_XLEN-1:0] read_reg(input reg_idx_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (i_wen && i_waddr == addr) begin
            return i_wdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        o_rdata_j = read_reg(i_raddr_j);
        o_rdata_k = read_reg(i_raddr_k);
    end

endmodule

`default_nettype wire

//--- logic/decode_unit.sv
`default_nettype none

`include "core_macros.svh"

module decode_unit import core_pkg::*; (
    input  logic                  i_valid,
    input  fetch_t                i_fetch,
    output reg_idx_t              o_raddr_j,
    output reg_idx_t              o_raddr_k,
    input  logic [`CORE_XLEN-1:0] i_rdata_j,
    input  logic [`CORE_XLEN-1:0] i_rdata_k,
    output logic                  o_valid,
    output issue_t                o_issue
);

    logic [5:0]            opcode;
    reg_idx_t              rd;
    reg_idx_t              rj;
    reg_idx_t              rk;
    logic [11:0]           si12;
    logic [19:0]           si20;
    logic [15:0]           offs16;
    core_op_t              op;
    logic                  is_branch;
    logic                  writes_reg;
    logic [`CORE_XLEN-1:0] imm;

    assign opcode = i_fetch.instr[`CORE_OP_HI:`CORE_OP_LO];
    assign rd     = i_fetch.instr[`CORE_RD_HI:`CORE_RD_LO];
    assign rj     = i_fetch.instr[`CORE_RJ_HI:`CORE_RJ_LO];
    assign rk     = i_fetch.instr[`CORE_RK_HI:`CORE_RK_LO];
    assign si12   = i_fetch.instr[`CORE_SI12_HI:`CORE_SI12_LO];
    assign si20   = i_fetch.instr[`CORE_SI20_HI:`CORE_SI20_LO];
    assign offs16 = i_fetch.instr[`CORE_OFFS16_HI:`CORE_OFFS16_LO];

    always_comb begin
        case (opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
            OP_ADDI, OP_LU12I, OP_BEQ, OP_BNE, OP_B: op = core_op_t'(opcode);
            default:                                 op = OP_NOP;
        endcase
    end

    assign is_branch  = op inside {OP_BEQ, OP_BNE, OP_B};
    assign writes_reg = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
                                   OP_ADDI, OP_LU12I};

    always_comb begin
        case (op)
            OP_ADDI:  imm = {{(`CORE_XLEN-12){si12[11]}}, si12};
            OP_LU12I: imm = {si20, {(`CORE_XLEN-20){1'b0}}};
            // word offset scaled to bytes
            OP_BEQ, OP_BNE, OP_B: imm = {{(`CORE_XLEN-18){offs16[15]}}, offs16, 2'b00};
            default:  imm = '0;
        endcase
    end

    // branches compare rj against rd
    assign o_raddr_j = rj;
    assign o_raddr_k = is_branch ? rd : rk;

    assign o_valid = i_valid;

    always_comb begin
        o_issue.pc    = i_fetch.pc;
        o_issue.op    = op;
        o_issue.rd    = rd;
        o_issue.rj    = o_raddr_j;
        o_issue.rk    = o_raddr_k;
        o_issue.val_j = i_rdata_j;
        o_issue.val_k = i_rdata_k;
        o_issue.imm   = imm;
        o_issue.wen   = writes_reg;
    end

endmodule

`default_nettype wire

//--- logic/execute_unit.sv
`default_nettype none

`include "core_macros.svh"

module execute_unit import core_pkg::*; (
    input  logic                  i_valid,
    input  issue_t                i_issue,
    input  logic                  i_fwd_valid,
    input  reg_idx_t              i_fwd_rd,
    input  logic [`CORE_XLEN-1:0] i_fwd_data,
    output logic                  o_redirect,
    output logic [`CORE_XLEN-1:0] o_redirect_pc,
    output logic                  o_valid,
    output logic [`CORE_XLEN-1:0] o_pc,
    output logic                  o_wen,
    output reg_idx_t              o_rd,
    output logic [`CORE_XLEN-1:0] o_data
);

    logic                  fwd_j;
    logic                  fwd_k;
    logic [`CORE_XLEN-1:0] opnd_j;
    logic [`CORE_XLEN-1:0] opnd_k;
    logic [`CORE_XLEN-1:0] result;
    logic                  taken;

    // operands read in decode may be one write behind
    assign fwd_j  = i_fwd_valid && i_issue.rj != '0 && i_fwd_rd == i_issue.rj;
    assign fwd_k  = i_fwd_valid && i_issue.rk != '0 && i_fwd_rd == i_issue.rk;
    assign opnd_j = fwd_j ? i_fwd_data : i_issue.val_j;
    assign opnd_k = fwd_k ? i_fwd_data : i_issue.val_k;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (i_issue.op)
            OP_ADD:   result = opnd_j + opnd_k;
            OP_SUB:   result = opnd_j - opnd_k;
            OP_AND:   result = opnd_j & opnd_k;
            OP_OR:    result = opnd_j | opnd_k;
            OP_XOR:   result = opnd_j ^ opnd_k;
            OP_SLT:   result = {{(`CORE_XLEN-1){1'b0}}, $signed(opnd_j) < $signed(opnd_k)};
            OP_ADDI:  result = opnd_j + i_issue.imm;
            OP_LU12I: result = i_issue.imm;
            OP_BEQ:   taken  = opnd_j == opnd_k;
            OP_BNE:   taken  = opnd_j != opnd_k;
            OP_B:     taken  = 1'b1;
            default:  result = '0;
        endcase
    end

    // taken branch flushes everything younger
    assign o_redirect    = i_valid & taken;
    assign o_redirect_pc = i_issue.pc + i_issue.imm;

    assign o_valid = i_valid;
    assign o_pc    = i_issue.pc;
    assign o_wen   = i_issue.wen;
    assign o_rd    = i_issue.rd;
    assign o_data  = result;

endmodule

`default_nettype wire

//--- logic/result_unit.sv
`default_nettype none

`include "core_macros.svh"

module result_unit import core_pkg::*; (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  i_valid,
    input  logic [`CORE_XLEN-1:0] i_pc,
    input  logic                  i_wen,
    input  reg_idx_t              i_rd,
    input  logic [`CORE_XLEN-1:0] i_data,
    output logic                  o_rf_wen,
    output reg_idx_t              o_rf_waddr,
    output logic [`CORE_XLEN-1:0] o_rf_wdata,
    output logic                  o_fwd_valid,
    output reg_idx_t              o_fwd_rd,
    output logic [`CORE_XLEN-1:0] o_fwd_data,
    output logic                  o_debug_valid,
    output logic [`CORE_XLEN-1:0] o_debug_pc,
    output logic [3:0]            o_debug_wen,
    output reg_idx_t              o_debug_wnum,
    output logic [`CORE_XLEN-1:0] o_debug_wdata
);

    logic                  valid_q;
    logic                  wen_q;
    logic [`CORE_XLEN-1:0] pc_q;
    logic [`CORE_XLEN-1:0] data_q;
    reg_idx_t              rd_q;
    logic                  write;

    // writes to r0 retire as no write
    assign write = i_valid && i_wen && i_rd != '0;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            valid_q <= 1'b0;
            wen_q   <= 1'b0;
        end else begin
            valid_q <= i_valid;
            wen_q   <= write;
        end
    end

    always_ff @(posedge aclk) begin
        pc_q   <= i_pc;
        rd_q   <= write ? i_rd : '0;
        data_q <= write ? i_data : '0;
    end

    assign o_rf_wen   = wen_q;
    assign o_rf_waddr = rd_q;
    assign o_rf_wdata = data_q;

    assign o_fwd_valid = wen_q;
    assign o_fwd_rd    = rd_q;
    assign o_fwd_data  = data_q;

    assign o_debug_valid = valid_q;
    assign o_debug_pc    = pc_q;
    assign o_debug_wen   = {4{wen_q}};
    assign o_debug_wnum  = rd_q;
    assign o_debug_wdata = data_q;

    no_trace_write_to_r0: assert property (@(posedge aclk) disable iff (!aresetn)
        o_debug_wen != 4'b0000 |-> o_debug_valid && o_debug_wnum != '0);

endmodule

`default_nettype wire

//--- logic/core_top.sv
`default_nettype none

`include "core_macros.svh"

module core_top import core_pkg::*; (
    input  logic                  aclk,
    input  logic                  aresetn,
    output logic                  o_wb_cyc,
    output logic                  o_wb_stb,
    output logic [`CORE_XLEN-1:0] o_wb_adr,
    output logic                  o_wb_we,
    input  logic [`CORE_XLEN-1:0] i_wb_dat,
    input  logic                  i_wb_ack,
    output logic                  o_debug_valid,
    output logic [`CORE_XLEN-1:0] o_debug_pc,
    output logic [3:0]            o_debug_wen,
    output reg_idx_t              o_debug_wnum,
    output logic [`CORE_XLEN-1:0] o_debug_wdata
);

    logic                  fetch_valid;
    fetch_t                fetch_data;
    logic                  fs_valid;
    fetch_t                fs_data;
    logic                  dec_valid;
    issue_t                dec_issue;
    logic                  is_valid;
    issue_t                is_issue;
    reg_idx_t              raddr_j;
    reg_idx_t              raddr_k;
    logic [`CORE_XLEN-1:0] rdata_j;
    logic [`CORE_XLEN-1:0] rdata_k;
    logic                  redirect;
    logic [`CORE_XLEN-1:0] redirect_pc;
    logic                  ex_valid;
    logic [`CORE_XLEN-1:0] ex_pc;
    logic                  ex_wen;
    reg_idx_t              ex_rd;
    logic [`CORE_XLEN-1:0] ex_data;
    logic                  rf_wen;
    reg_idx_t              rf_waddr;
    logic [`CORE_XLEN-1:0] rf_wdata;
    logic                  fwd_valid;
    reg_idx_t              fwd_rd;
    logic [`CORE_XLEN-1:0] fwd_data;

    fetch_unit fetch_unit_i (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .o_wb_cyc      (o_wb_cyc),
        .o_wb_stb      (o_wb_stb),
        .o_wb_we       (o_wb_we),
        .o_wb_adr      (o_wb_adr),
        .i_wb_dat      (i_wb_dat),
        .i_wb_ack      (i_wb_ack),
        .o_valid       (fetch_valid),
        .o_fetch       (fetch_data)
    );

    stage_reg #(.payload_t(fetch_t)) fetch_stage_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_flush (redirect),
        .i_valid (fetch_valid),
        .i_data  (fetch_data),
        .o_valid (fs_valid),
        .o_data  (fs_data)
    );

    decode_unit decode_unit_i (
        .i_valid   (fs_valid),
        .i_fetch   (fs_data),
        .o_raddr_j (raddr_j),
        .o_raddr_k (raddr_k),
        .i_rdata_j (rdata_j),
        .i_rdata_k (rdata_k),
        .o_valid   (dec_valid),
        .o_issue   (dec_issue)
    );

    register_file register_file_i (
        .aclk      (aclk),
        .i_raddr_j (raddr_j),
        .i_raddr_k (raddr_k),
        .o_rdata_j (rdata_j),
        .o_rdata_k (rdata_k),
        .i_wen     (rf_wen),
        .i_waddr   (rf_waddr),
        .i_wdata   (rf_wdata)
    );

    stage_reg #(.payload_t(issue_t)) issue_stage_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_flush (redirect),
        .i_valid (dec_valid),
        .i_data  (dec_issue),
        .o_valid (is_valid),
        .o_data  (is_issue)
    );

    execute_unit execute_unit_i (
        .i_valid       (is_valid),
        .i_issue       (is_issue),
        .i_fwd_valid   (fwd_valid),
        .i_fwd_rd      (fwd_rd),
        .i_fwd_data    (fwd_data),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc),
        .o_valid       (ex_valid),
        .o_pc          (ex_pc),
        .o_wen         (ex_wen),
        .o_rd          (ex_rd),
        .o_data        (ex_data)
    );

    result_unit result_unit_i (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_valid       (ex_valid),
        .i_pc          (ex_pc),
        .i_wen         (ex_wen),
        .i_rd          (ex_rd),
        .i_data        (ex_data),
        .o_rf_wen      (rf_wen),
        .o_rf_waddr    (rf_waddr),
        .o_rf_wdata    (rf_wdata),
        .o_fwd_valid   (fwd_valid),
        .o_fwd_rd      (fwd_rd),
        .o_fwd_data    (fwd_data),
        .o_debug_valid (o_debug_valid),
        .o_debug_pc    (o_debug_pc),
        .o_debug_wen   (o_debug_wen),
        .o_debug_wnum  (o_debug_wnum),
        .o_debug_wdata (o_debug_wdata)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic aclk,
    output logic aresetn
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        aclk = 1'b0;
        forever #(PERIOD_NS / 2) aclk = ~aclk;
    end

    // reset released on a rising edge
    initial begin
        aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        aresetn <= 1'b1;
    end

endmodule

`default_nettype wire

//--- bench/tb_core.sv
`default_nettype none

`include "core_macros.svh"

module tb_core import core_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned SEED = 32'h56f5;
    localparam int MAX_WAIT    = 3;
    localparam int WDOG_MARGIN = 200;
    localparam int MEM_WORDS   = 256;
    localparam int DATA_WORDS  = 512;
    // records start at word 0x100 of the data file, five words each
    localparam int REC_BASE    = 256;
    localparam int REC_WIDTH   = 5;
    localparam int REC_MAX     = (DATA_WORDS - REC_BASE) / REC_WIDTH;

    logic                  aclk;
    logic                  aresetn;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic [`CORE_XLEN-1:0] wb_adr;
    logic                  wb_we;
    logic [`CORE_XLEN-1:0] wb_dat = '0;
    logic                  wb_ack = 1'b0;
    logic                  dbg_valid;
    logic [`CORE_XLEN-1:0] dbg_pc;
    logic [3:0]            dbg_wen;
    reg_idx_t              dbg_wnum;
    logic [`CORE_XLEN-1:0] dbg_wdata;

    logic [`CORE_XLEN-1:0] tdata [DATA_WORDS];
    logic [`CORE_XLEN-1:0] prog_mem [MEM_WORDS];

    int          n_records       = 0;
    int          rec_idx         = 0;
    int          n_errors        = 0;
    int          n_tests         = 0;
    int          test_errors     = 0;
    int          test_checked    = 0;
    int          watchdog_cycles = 0;
    bit          loaded          = 1'b0;
    bit          wb_busy         = 1'b0;
    int unsigned wait_left       = 0;

    tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(16)) clock_i (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    core_top dut_i (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .o_wb_cyc      (wb_cyc),
        .o_wb_stb      (wb_stb),
        .o_wb_adr      (wb_adr),
        .o_wb_we       (wb_we),
        .i_wb_dat      (wb_dat),
        .i_wb_ack      (wb_ack),
        .o_debug_valid (dbg_valid),
        .o_debug_pc    (dbg_pc),
        .o_debug_wen   (dbg_wen),
        .o_debug_wnum  (dbg_wnum),
        .o_debug_wdata (dbg_wdata)
    );

    function automatic string test_name(input logic [31:0] tag);
        case (tag)
            1:       return "alu_basic";
            2:       return "lu12i_build";
            3:       return "forwarding";
            4:       return "reg_zero";
            5:       return "branches";
            6:       return "unknown_op";
            default: return "unknown_tag";
        endcase
    endfunction

    function automatic logic [31:0] rec_field(input int idx, input int field);
        return tdata[9'(REC_BASE + idx * REC_WIDTH + field)];
    endfunction

    function automatic string op_label(input logic [31:0] word);
        core_op_t op;
        op = core_op_t'(word[`CORE_OP_HI:`CORE_OP_LO]);
        if (op.name() == "") begin
            return "undefined op";
        end
        return op.name();
    endfunction

    task automatic compare_value(input string where, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s %s: expected 0x%08h, actual 0x%08h",
                     where, field, expected, actual);
            n_errors++;
            test_errors++;
        end
    endtask

    task automatic check_record();
        logic [31:0] tag;
        logic [31:0] exp_pc;
        logic        exp_wen;
        logic [31:0] exp_rd;
        logic [31:0] exp_val;
        string       where;
        tag     = rec_field(rec_idx, 0);
        exp_pc  = rec_field(rec_idx, 1);
        exp_wen = rec_field(rec_idx, 2) != 0;
        exp_rd  = rec_field(rec_idx, 3);
        exp_val = rec_field(rec_idx, 4);
        where   = $sformatf("%s at pc %08h (%s)", test_name(tag), exp_pc,
                            op_label(prog_mem[exp_pc[9:2]]));
        compare_value(where, "pc", exp_pc, dbg_pc);
        compare_value(where, "wen", exp_wen ? 32'hf : 32'h0, 32'(dbg_wen));
        compare_value(where, "wnum", exp_rd, 32'(dbg_wnum));
        compare_value(where, "wdata", exp_val, dbg_wdata);
        test_checked++;
        rec_idx++;
        // next tag differs, so this test is complete
        if (rec_field(rec_idx, 0) != tag) begin
            $display("test %s finished: %0d records, %0d mismatches",
                     test_name(tag), test_checked, test_errors);
            n_tests++;
            test_checked = 0;
            test_errors  = 0;
        end
    endtask

    // wishbone slave with 0 to 3 wait states per request
    initial begin : wb_slave
        int unsigned draw;
        string       where;
        void'($urandom(SEED));
        forever begin
            @(posedge aclk);
            if (!aresetn) begin
                wb_ack    <= 1'b0;
                wb_busy   <= 1'b0;
                wait_left <= 0;
            end else if (wb_ack) begin
                wb_ack  <= 1'b0;
                wb_busy <= 1'b0;
            end else if (wb_busy) begin
                if (wait_left == 0) begin
                    wb_ack <= 1'b1;
                    wb_dat <= prog_mem[wb_adr[9:2]];
                end else begin
                    wait_left <= wait_left - 1;
                end
            end else if (wb_cyc && wb_stb) begin
                // instruction fetch is a word-aligned read
                where = $sformatf("%s wishbone request at %08h",
                                  test_name(rec_field(rec_idx, 0)), wb_adr);
                compare_value(where, "we", 32'h0, 32'(wb_we));
                compare_value(where, "adr[1:0]", 32'h0, 32'(wb_adr[1:0]));
                draw = $urandom % (MAX_WAIT + 1);
                if (draw == 0) begin
                    wb_ack <= 1'b1;
                    wb_dat <= prog_mem[wb_adr[9:2]];
                end else begin
                    wb_busy   <= 1'b1;
                    wait_left <= draw - 1;
                end
            end
        end
    end

    // trace sampled mid-cycle
    always @(negedge aclk) begin
        if (aresetn && dbg_valid && rec_idx < n_records) begin
            check_record();
        end
    end

    initial begin
        for (int i = 0; i < DATA_WORDS; i++) begin
            tdata[9'(i)] = 32'hfc00_0000 | 32'(i);
        end
        $readmemh("bench/core_testdata.hex", tdata);
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog_mem[8'(i)] = tdata[9'(i)];
        end
        while (n_records < REC_MAX && rec_field(n_records, 0) != 0) begin
            n_records++;
        end
        if (n_records == 0) begin
            $display("no expected records found in the test data file");
        end
        watchdog_cycles = n_records * (MAX_WAIT + 1) * 8 + WDOG_MARGIN;
        loaded = 1'b1;
        wait (aresetn === 1'b1);
        wait (rec_idx >= n_records);
        @(posedge aclk);
        $display("checked %0d of %0d records in %0d tests, %0d errors",
                 rec_idx, n_records, n_tests, n_errors);
        if (n_errors == 0 && n_records > 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        wait (loaded);
        wait (aresetn === 1'b1);
        repeat (watchdog_cycles) @(posedge aclk);
        $display("timeout after %0d cycles: test %s stalled at record %0d of %0d",
                 watchdog_cycles, test_name(rec_field(rec_idx, 0)), rec_idx, n_records);
        $display("checked %0d of %0d records in %0d tests, %0d errors",
                 rec_idx, n_records, n_tests, n_errors);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
logic/core_pkg.sv
logic/fetch_unit.sv
logic/stage_reg.sv
logic/register_file.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/result_unit.sv
logic/core_top.sv
bench/tb_clock.sv
bench/tb_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the core bench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_core -f filelist.f -o sim_core

./obj_dir/sim_core | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

echo "simulation passed"

//--- bench/core_testdata.hex
// program words from @000, one instruction word per entry
// records from @100, one per line: tag pc wen rd value (tag 0 ends the list)
@000
// alu_basic
20001401 203ff402 04000823 08000824 0c000825
10000826 14000827 18000448 18000829 203e704a
// lu12i_build
242468ab 2019e16b 25bd5b8c 203bbd8c
// forwarding
20001c0d 040035ae 040035cf 08003dd0 14003a11
// reg_zero
2001ec20 04000420 04000412
// branches, wrong-path words hold addi r20 or r21
40000c24 44000c25 40000825 201ffc14 44000c24 201ffc14
201ffc15 48000c00 20002415 48000c00 4bfff800 201ffc14
040006b6
// unknown_op, then a branch to itself
1c000421 20000437 48000000
@100
1 00000000 1 01 00000005
1 00000004 1 02 fffffffd
1 00000008 1 03 00000002
1 0000000c 1 04 00000008
1 00000010 1 05 00000005
1 00000014 1 06 fffffffd
1 00000018 1 07 fffffff8
1 0000001c 1 08 00000001
1 00000020 1 09 00000000
1 00000024 1 0a ffffff99
2 00000028 1 0b 12345000
2 0000002c 1 0b 12345678
2 00000030 1 0c deadc000
2 00000034 1 0c deadbeef
3 00000038 1 0d 00000007
3 0000003c 1 0e 0000000e
3 00000040 1 0f 00000015
3 00000044 1 10 fffffff9
3 00000048 1 11 fffffff7
4 0000004c 0 00 00000000
4 00000050 0 00 00000000
4 00000054 1 12 00000005
5 00000058 0 00 00000000
5 0000005c 0 00 00000000
5 00000060 0 00 00000000
5 00000068 0 00 00000000
5 00000074 0 00 00000000
5 00000080 0 00 00000000
5 00000078 1 15 00000009
5 0000007c 0 00 00000000
5 00000088 1 16 0000000e
6 0000008c 0 00 00000000
6 00000090 1 17 00000006
0 00000000 0 00 00000000
